// ==== hdl/float_divider.sv ====
`timescale 1ns/100ps

module float_divider
	import fpu_pkg::*;
	import float_fmt_pkg::*;
(
	input	logic		clk,
	input	logic		reset,
	input	logic		flush,

	input	logic		valid_in,
	output	logic		ready_out,
	output	logic		valid_out,
	input	logic		ready_in,

	input	fpu_op_t	op,
	input	rm_t		rm,

	input	unpacked_t	operand_a,
	input	unpacked_t	operand_b,

	output	quotient_t	quotient,
	output	logic		nv,
	output	logic		dz,
	output	rm_t		rm_out
);

	typedef enum logic {IDLE, CALC} state_t;

	state_t state;
	logic [3:0] counter;
	logic spec_pend;	// special result waits one edge

	man_t divisor;
	logic [25:0] res;
	logic [26:0] rem;
	exp_t exp_q;
	logic sgn_q;
	logic skip_round;

	logic [26:0] acc [3];
	logic [26:0] diff;
	logic [1:0] q;

	logic accept;
	logic is_nan;
	logic is_inf;
	logic is_zero;
	logic special;

	assign ready_out = ready_in && (state == IDLE) && !spec_pend;
	assign accept = valid_in && (op == FPU_OP_DIV) && ready_out;

	assign is_nan = operand_a.snan || operand_b.snan || operand_a.qnan || operand_b.qnan ||
		(operand_a.zero && operand_b.zero) || (operand_a.inf && operand_b.inf);
	assign is_inf = operand_a.inf || operand_b.zero;
	assign is_zero = operand_a.zero || operand_b.inf;
	assign special = is_nan || is_inf || is_zero;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= IDLE;
			counter <= 4'd0;
			spec_pend <= 1'b0;
			valid_out <= 1'b0;
		end else if (flush) begin
			state <= IDLE;
			counter <= 4'd0;
			spec_pend <= 1'b0;
			valid_out <= 1'b0;
		end else if (accept) begin
			state <= special ? IDLE : CALC;
			counter <= 4'd0;
			spec_pend <= special;
			valid_out <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (spec_pend) begin
						spec_pend <= 1'b0;
						valid_out <= 1'b1;
					end else if (valid_out && ready_in) begin
						valid_out <= 1'b0;	// result taken
					end
				end
				CALC: begin
					if (counter == 4'd12) begin
						state <= IDLE;
						valid_out <= 1'b1;
					end else begin
						counter <= counter + 4'd1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			divisor <= '0;
			res <= '0;
			rem <= '0;
			exp_q <= '0;
			sgn_q <= 1'b0;
			skip_round <= 1'b0;
			nv <= 1'b0;
			dz <= 1'b0;
			rm_out <= RM_RNE;
		end else if (accept) begin
			sgn_q <= operand_a.sgn ^ operand_b.sgn;
			skip_round <= special;
			nv <= 1'b0;
			dz <= 1'b0;
			rm_out <= rm;
			rem <= '0;
			if (is_nan) begin
				res <= {1'b1, CANON_NAN[FRAC_W-1:0], 2'b00};
				exp_q <= exp_t'(EXP_MAX);
				sgn_q <= CANON_NAN[EXP_W+FRAC_W];
				nv <= !(operand_a.qnan || operand_b.qnan);
			end else if (is_inf) begin
				res <= {1'b1, FRAC_W'(0), 2'b00};
				exp_q <= exp_t'(EXP_MAX);
				dz <= operand_b.zero;
			end else if (is_zero) begin
				res <= '0;
				exp_q <= '0;
			end else begin
				divisor <= operand_b.man;
				res <= '0;
				rem <= {1'b0, operand_a.man, 2'b00};
				exp_q <= operand_a.exp - operand_b.exp;
			end
		end else if (state == CALC) begin
			res <= {res[23:0], q};
			rem <= acc[2];
		end
	end

	// two restoring steps per cycle
	always_comb begin
		acc[0] = rem;
		for (int i = 1; i <= 2; i++) begin
			diff = acc[i-1] - {1'b0, divisor, 2'b00};
			q[2-i] = !diff[26];
			acc[i] = (diff[26] ? acc[i-1] : diff) << 1;
		end
	end

	always_comb begin
		quotient.sgn = sgn_q;
		quotient.skip_round = skip_round;
		if (res[25] || skip_round) begin
			quotient.man = res[25:2];
			quotient.exp = exp_q;
			quotient.round_bit = res[1];
			quotient.sticky_bit = res[0] || (|rem);
		end else begin
			quotient.man = res[24:1];	// ratio below one, shift up
			quotient.exp = exp_q - 10'sd1;
			quotient.round_bit = res[0];
			quotient.sticky_bit = |rem;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		(state == CALC) && (counter < 4'd12) |=> !valid_out)
		else $error("valid_out raised before the last divide step");

	assert property (@(posedge clk) disable iff (reset)
		(state == CALC) |-> divisor[FRAC_W])
		else $error("divisor not normalized during divide");

endmodule

// ==== hdl/float_fmt_pkg.sv ====
package float_fmt_pkg;

	localparam int EXP_W = 8;
	localparam int FRAC_W = 23;

	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX = 255;	// all-ones exponent field

	typedef logic [EXP_W+FRAC_W:0] fp32_t;

	// mantissa including the hidden bit
	typedef logic [FRAC_W:0] man_t;

	// two extra bits so quotient exponents can go negative or past 255
	typedef logic signed [EXP_W+1:0] exp_t;

	localparam fp32_t CANON_NAN = 32'h7fc00000;

	typedef struct packed {
		man_t man;
		exp_t exp;	// biased, as found in the word
		logic sgn;
		logic zero;	// subnormals land here too
		logic inf;
		logic snan;
		logic qnan;
	} unpacked_t;

	typedef struct packed {
		man_t man;
		exp_t exp;	// exp_a - exp_b, no bias
		logic sgn;
		logic round_bit;
		logic sticky_bit;
		logic skip_round;	// special result, pack as is
	} quotient_t;

endpackage

// ==== hdl/float_round_pack.sv ====
`timescale 1ns/100ps

module float_round_pack
	import fpu_pkg::*;
	import float_fmt_pkg::*;
(
	input	quotient_t	quotient,
	input	logic		nv,
	input	logic		dz,
	input	rm_t		rm,
	output	fp32_t		y,
	output	fflags_t	flags
);

	logic inexact;
	logic inc;
	logic [24:0] man_rnd;
	man_t man_norm;
	exp_t exp_biased;
	exp_t exp_norm;
	logic overflow;
	logic underflow;
	logic max_finite;

	assign inexact = quotient.round_bit || quotient.sticky_bit;

	always_comb begin
		case (rm)
			RM_RNE: inc = quotient.round_bit && (quotient.sticky_bit || quotient.man[0]);
			RM_RTZ: inc = 1'b0;
			RM_RDN: inc = quotient.sgn && inexact;
			RM_RUP: inc = !quotient.sgn && inexact;
			RM_RMM: inc = quotient.round_bit;
			default: inc = 1'b0;	// reserved modes truncate
		endcase
	end

	assign exp_biased = quotient.exp + exp_t'(EXP_BIAS);
	assign man_rnd = {1'b0, quotient.man} + {24'd0, inc};

	// carry out of the mantissa means 1.111.. rounded to 10.000..
	assign man_norm = man_rnd[24] ? man_rnd[24:1] : man_rnd[23:0];
	assign exp_norm = man_rnd[24] ? exp_biased + 10'sd1 : exp_biased;

	assign overflow = exp_norm >= exp_t'(EXP_MAX);
	assign underflow = exp_norm <= 10'sd0;

	// directed modes that point toward zero saturate
	assign max_finite = (rm == RM_RTZ) || ((rm == RM_RDN) && !quotient.sgn) ||
		((rm == RM_RUP) && quotient.sgn);

	always_comb begin
		flags.nv = nv;
		flags.dz = dz;
		flags.of = 1'b0;
		flags.uf = 1'b0;
		flags.nx = 1'b0;
		if (quotient.skip_round) begin
			y = {quotient.sgn, quotient.exp[EXP_W-1:0], quotient.man[FRAC_W-1:0]};
		end else if (overflow) begin
			flags.of = 1'b1;
			flags.nx = 1'b1;
			if (max_finite)
				y = {quotient.sgn, EXP_W'(EXP_MAX - 1), {FRAC_W{1'b1}}};
			else
				y = {quotient.sgn, EXP_W'(EXP_MAX), FRAC_W'(0)};
		end else if (underflow) begin
			flags.uf = 1'b1;
			flags.nx = 1'b1;
			y = {quotient.sgn, (EXP_W + FRAC_W)'(0)};	// flush to zero
		end else begin
			flags.nx = inexact;
			y = {quotient.sgn, exp_norm[EXP_W-1:0], man_norm[FRAC_W-1:0]};
		end
	end

endmodule

// ==== hdl/float_unpack.sv ====
`timescale 1ns/100ps

module float_unpack
	import float_fmt_pkg::*;
(
	input	fp32_t		fp32,
	output	unpacked_t	operand
);

	logic [EXP_W-1:0] exp_field;
	logic [FRAC_W-1:0] frac;
	logic exp_zero;
	logic exp_ones;

	assign exp_field = fp32[FRAC_W +: EXP_W];
	assign frac = fp32[FRAC_W-1:0];

	assign exp_zero = exp_field == '0;
	assign exp_ones = exp_field == EXP_W'(EXP_MAX);

	always_comb begin
		operand.sgn = fp32[EXP_W+FRAC_W];
		operand.exp = {2'b00, exp_field};
		operand.man = exp_zero ? '0 : {1'b1, frac};	// hidden bit

		// denormals are not supported, they read as zero
		operand.zero = exp_zero;

		operand.inf = exp_ones && (frac == '0);
		operand.snan = exp_ones && (frac != '0) && !frac[FRAC_W-1];
		operand.qnan = exp_ones && frac[FRAC_W-1];
	end

endmodule

// ==== hdl/fpu_div_unit.sv ====
`timescale 1ns/100ps

module fpu_div_unit
	import fpu_pkg::*;
	import float_fmt_pkg::*;
(
	input	logic		clk,
	input	logic		reset,
	input	logic		flush,

	input	logic		valid_in,
	output	logic		ready_out,
	output	logic		valid_out,
	input	logic		ready_in,

	input	fpu_op_t	op,
	input	rm_t		rm,
	input	fp32_t		a,
	input	fp32_t		b,

	output	fp32_t		y,
	output	fflags_t	flags
);

	unpacked_t operand_a;
	unpacked_t operand_b;
	quotient_t quotient;
	logic nv;
	logic dz;
	rm_t rm_q;	// mode captured with the request

	float_unpack unpack_a (.fp32(a), .operand(operand_a));
	float_unpack unpack_b (.fp32(b), .operand(operand_b));

	float_divider divider (
		.clk(clk), .reset(reset), .flush(flush),
		.valid_in(valid_in), .ready_out(ready_out),
		.valid_out(valid_out), .ready_in(ready_in),
		.op(op), .rm(rm),
		.operand_a(operand_a), .operand_b(operand_b),
		.quotient(quotient), .nv(nv), .dz(dz), .rm_out(rm_q)
	);

	float_round_pack round_pack (
		.quotient(quotient), .nv(nv), .dz(dz), .rm(rm_q),
		.y(y), .flags(flags)
	);

endmodule

// ==== hdl/fpu_pkg.sv ====
package fpu_pkg;

	// operation code as issued to the FPU
	typedef logic [4:0] fpu_op_t;

	// rounding mode, RISC-V frm encoding
	typedef logic [2:0] rm_t;

	localparam fpu_op_t FPU_OP_DIV = 5'd3;

	localparam rm_t RM_RNE = 3'd0;	// nearest, ties to even
	localparam rm_t RM_RTZ = 3'd1;	// toward zero
	localparam rm_t RM_RDN = 3'd2;	// toward -inf
	localparam rm_t RM_RUP = 3'd3;	// toward +inf
	localparam rm_t RM_RMM = 3'd4;	// nearest, ties away from zero

	// accrued exception flags, nv in bit 4 down to nx in bit 0
	typedef struct packed {
		logic nv;	// invalid operation
		logic dz;	// divide by zero
		logic of;	// overflow
		logic uf;	// underflow
		logic nx;	// inexact
	} fflags_t;

endpackage

// ==== list.f ====
+incdir+verification
hdl/fpu_pkg.sv
hdl/float_fmt_pkg.sv
hdl/float_unpack.sv
hdl/float_divider.sv
hdl/float_round_pack.sv
hdl/fpu_div_unit.sv
verification/fpu_div_tb.sv

// ==== verification/div_model.svh ====
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

typedef struct packed {
	fp32_t y;
	fflags_t flags;
} div_result_t;

function automatic logic has_special_operand(fp32_t x, fp32_t d);
	return (x[30:23] == 8'd0) || (x[30:23] == 8'hff) || (d[30:23] == 8'd0) || (d[30:23] == 8'hff);
endfunction

function automatic div_result_t expected_quotient(fp32_t x, fp32_t d, rm_t mode);
	div_result_t res;
	int e;
	logic s;
	logic x_nan;
	logic d_nan;
	logic [25:0] q;
	logic [24:0] r;
	logic [24:0] m;
	logic g;
	logic st;
	logic up;
	res.flags = '0;
	s = x[31] ^ d[31];
	x_nan = (x[30:23] == 8'hff) && (x[22:0] != 0);
	d_nan = (d[30:23] == 8'hff) && (d[22:0] != 0);
	if (x_nan || d_nan || (x[30:0] == 31'h7f800000 && d[30:0] == 31'h7f800000) ||
		(x[30:23] == 0 && d[30:23] == 0)) begin
		res.y = 32'h7fc00000;
		res.flags.nv = !((x_nan && x[22]) || (d_nan && d[22]));	// quiet NaN stays silent
		return res;
	end
	if (x[30:23] == 8'hff || d[30:23] == 8'd0) begin
		res.y = {s, 8'hff, 23'd0};
		res.flags.dz = d[30:23] == 8'd0;
		return res;
	end
	if (x[30:23] == 8'd0 || d[30:23] == 8'hff) begin
		res.y = {s, 31'd0};
		return res;
	end
	e = int'(x[30:23]) - int'(d[30:23]) + 127;
	r = {2'b01, x[22:0]};
	q = '0;
	for (int i = 0; i < 26; i++) begin	// one quotient bit per step
		q = q << 1;
		if (r >= {2'b01, d[22:0]}) begin
			q[0] = 1'b1;
			r = r - {2'b01, d[22:0]};
		end
		r = r << 1;
	end
	if (!q[25]) begin
		q = q << 1;
		e = e - 1;
	end
	m = {1'b0, q[25:2]};
	g = q[1];
	st = q[0] || (r != 0);
	case (mode)
		RM_RNE: up = g && (st || m[0]);
		RM_RDN: up = s && (g || st);
		RM_RUP: up = !s && (g || st);
		RM_RMM: up = g;
		default: up = 1'b0;
	endcase
	m = m + up;
	if (m[24]) begin
		m = m >> 1;
		e = e + 1;
	end
	if (e >= 255) begin
		res.flags = 5'b00101;
		if (mode == RM_RTZ || (mode == RM_RDN && !s) || (mode == RM_RUP && s))
			res.y = {s, 8'hfe, 23'h7fffff};
		else
			res.y = {s, 8'hff, 23'd0};
	end else if (e <= 0) begin
		res.flags = 5'b00011;
		res.y = {s, 31'd0};
	end else begin
		res.flags.nx = g || st;
		res.y = {s, e[7:0], m[22:0]};
	end
	return res;
endfunction

`endif

// ==== verification/fpu_div_tb.sv ====
`timescale 1ns/100ps

module fpu_div_tb
	import fpu_pkg::*;
	import float_fmt_pkg::*;
();

	logic clk;
	logic reset;
	logic flush;
	logic valid_in;
	logic ready_in;
	logic ready_out;
	logic valid_out;
	fpu_op_t op;
	rm_t rm;
	fp32_t a;
	fp32_t b;
	fp32_t y;
	fflags_t flags;

	fp32_t exp_y;
	fflags_t exp_flags;
	logic expect_result;	// a divide is in flight or waiting
	logic spec_req;
	int errors;
	int tests_run;
	int tests_failed;
	int test_start;

	// snan, 0/0, inf/inf, qnan, x/0, 0/x, x/inf and a subnormal divisor
	fp32_t spec_a [12] = '{32'h7f800001, 32'h3f800000, 32'h00000000, 32'h7f800000,
		32'h7fc00000, 32'hc0200000, 32'h3f800000, 32'hc0200000, 32'h3f800000,
		32'h80000000, 32'hc0200000, 32'hff800000};
	fp32_t spec_b [12] = '{32'h3f800000, 32'hff800001, 32'h80000000, 32'hff800000,
		32'h3f800000, 32'h7fc12345, 32'h00000000, 32'h00000000, 32'h80000001,
		32'h3f800000, 32'h7f800000, 32'h3f800000};

	`include "div_model.svh"

	fpu_div_unit dut (.clk(clk), .reset(reset), .flush(flush), .valid_in(valid_in),
		.ready_out(ready_out), .valid_out(valid_out), .ready_in(ready_in), .op(op),
		.rm(rm), .a(a), .b(b), .y(y), .flags(flags));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_check(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		errors++;
	endtask

	assert property (@(posedge clk) disable iff (reset)
		valid_out |-> (y == exp_y) && (flags == exp_flags))
		else report_check($sformatf("y %h flags %b, expected %h flags %b",
			$sampled(y), $sampled(flags), $sampled(exp_y), $sampled(exp_flags)));

	assert property (@(posedge clk) disable iff (reset || flush)
		valid_in && ready_out && (op == FPU_OP_DIV) && !spec_req |=>
		(!valid_out && !ready_out) [*13] ##1 valid_out)
		else report_check("normal divide latency or ready_out wrong");

	assert property (@(posedge clk) disable iff (reset || flush)
		valid_in && ready_out && (op == FPU_OP_DIV) && spec_req |=>
		(!valid_out && !ready_out) ##1 valid_out)
		else report_check("special divide latency or ready_out wrong");

	assert property (@(posedge clk) disable iff (reset) $rose(valid_out) |-> expect_result)
		else report_check("valid_out rose with no divide pending");

	assert property (@(posedge clk) disable iff (reset)
		valid_out && !ready_in |=> valid_out && $stable(y) && $stable(flags))
		else report_check("result changed while stalled");

	assert property (@(posedge clk) disable iff (reset) valid_out && !ready_in |-> !ready_out)
		else report_check("ready_out high while stalled");

	assert property (@(posedge clk) disable iff (reset)
		valid_out && ready_in && !valid_in |=> !valid_out)
		else report_check("valid_out held after transfer");

	function automatic fp32_t random_normal();
		return {1'($urandom % 2), 8'(90 + $urandom % 71), 23'($urandom)};	// quotient stays in range
	endfunction

	task automatic send_request(input fpu_op_t req_op, input rm_t req_rm,
		input fp32_t req_a, input fp32_t req_b);
		div_result_t expected;
		int n;
		n = 0;
		while (!ready_out && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (!ready_out) begin
			$display("timeout at %0t: ready_out never went high", $time);
			errors++;
		end
		op = req_op;
		rm = req_rm;
		a = req_a;
		b = req_b;
		if (req_op == FPU_OP_DIV) begin
			expected = expected_quotient(req_a, req_b, req_rm);
			exp_y = expected.y;
			exp_flags = expected.flags;
			spec_req = has_special_operand(req_a, req_b);
			expect_result = 1'b1;
		end
		valid_in = 1'b1;
		@(negedge clk);
		valid_in = 1'b0;
	endtask

	task automatic wait_for_valid();
		int n;
		n = 0;
		while (!valid_out && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (!valid_out) begin
			$display("timeout at %0t: valid_out never went high", $time);
			errors++;
		end
	endtask

	task automatic take_result();
		wait_for_valid();
		@(negedge clk);	// ready_in is high, so the transfer happened
		expect_result = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_start);
		end
		test_start = errors;
	endtask

	initial begin
		void'($urandom(32'h17d));
		{errors, tests_run, tests_failed, test_start} = '0;
		reset = 1'b1;
		flush = 1'b0;
		valid_in = 1'b0;
		ready_in = 1'b1;
		op = FPU_OP_DIV;
		rm = RM_RNE;
		a = '0;
		b = '0;
		exp_y = '0;
		exp_flags = '0;
		expect_result = 1'b0;
		spec_req = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		for (int m = 0; m < 5; m++) begin
			for (int i = 0; i < 40; i++) begin
				send_request(FPU_OP_DIV, rm_t'(m), random_normal(), random_normal());
				take_result();
			end
		end
		end_test("random normal operands");

		for (int i = 0; i < 12; i++) begin
			send_request(FPU_OP_DIV, rm_t'(i % 5), spec_a[i], spec_b[i]);
			take_result();
		end
		end_test("special operands");

		send_request(FPU_OP_DIV, RM_RNE, 32'h3fc00000, 32'h3f400000);
		take_result();
		send_request(FPU_OP_DIV, RM_RNE, 32'h7f800000, 32'h3f800000);
		take_result();
		end_test("latency");

		send_request(FPU_OP_DIV, RM_RNE, 32'h40490fdb, 32'h402df854);
		ready_in = 1'b0;
		wait_for_valid();
		repeat (5) @(negedge clk);
		ready_in = 1'b1;
		@(negedge clk);
		expect_result = 1'b0;
		end_test("back-pressure");

		send_request(FPU_OP_DIV, RM_RNE, 32'h40490fdb, 32'h3f9e0419);
		repeat (5) @(negedge clk);
		flush = 1'b1;
		expect_result = 1'b0;	// flushed divide must stay silent
		@(negedge clk);
		flush = 1'b0;
		repeat (16) @(negedge clk);
		send_request(5'd0, RM_RNE, 32'h3f800000, 32'h40000000);
		repeat (16) @(negedge clk);
		end_test("flush and foreign op");

		for (int m = 0; m < 5; m++) begin
			send_request(FPU_OP_DIV, rm_t'(m), 32'h7f000000, 32'h3e800000);
			take_result();
			send_request(FPU_OP_DIV, rm_t'(m), 32'hff000000, 32'h3e800000);
			take_result();
			send_request(FPU_OP_DIV, rm_t'(m), 32'h00800000, 32'h41000000);
			take_result();
			send_request(FPU_OP_DIV, rm_t'(m), 32'h80800000, 32'h41000000);
			take_result();
		end
		end_test("range limits");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
